/* src/ssu_pkg.sv */
/*
 * Shared widths, confidence encodings and packed structs of the store set updater.
 * Imported by every stage from the capture buffers through to the resolve stage.
 */
package ssu_pkg;

    // ------------------------------------------------------------------------
    // widths
    localparam int CONF_W    = 2;
    localparam int SSID_W    = 6;
    localparam int ROB_IDX_W = 7;

    // confidence encodings
    localparam logic [CONF_W-1:0] CONF_NONE    = 2'd0;
    localparam logic [CONF_W-1:0] CONF_DECAYED = 2'd1;
    localparam logic [CONF_W-1:0] CONF_FULL    = 2'd3;

    // ------------------------------------------------------------------------
    // memory dependence info as held by the ROB
    typedef struct packed {
        logic [CONF_W-1:0] conf;
        logic [SSID_W-1:0] ssid;
    } mdp_info_t;

    // mdp tagged with the instruction it belongs to
    typedef struct packed {
        mdp_info_t            mdp;
        logic [ROB_IDX_W-1:0] rob_idx;
    } mdp_ref_t;

    // dependent load and store pair found by a CAM
    typedef struct packed {
        mdp_ref_t ld;
        mdp_ref_t stamo;
    } cam_update_t;

    // funnel queue entry, A then B are resolved in order
    typedef struct packed {
        logic     is_cam;
        logic     a_valid;
        mdp_ref_t a;
        logic     b_valid;
        mdp_ref_t b;
    } funnel_entry_t;

    typedef struct packed {
        logic                 valid;
        mdp_info_t            mdp;
        logic [ROB_IDX_W-1:0] rob_idx;
    } rob_update_t;

endpackage

/* src/ssu_cb.sv */
/*
 * Small circular buffer for incoming updates. A push into a full buffer drops
 * the oldest entry so the youngest updates are always kept.
 */
`timescale 1ns/1ps

module ssu_cb #(
    parameter int  INPUT_BUF_ENTRIES = 2,
    parameter type entry_t           = logic [7:0]
) (
    input  logic   CLK,
    input  logic   nRST,
    input  logic   push,
    input  entry_t push_data,
    output logic   valid,
    output entry_t data,
    input  logic   pop
);

    localparam int PTR_W = (INPUT_BUF_ENTRIES > 1) ? $clog2(INPUT_BUF_ENTRIES) : 1;
    localparam int CNT_W = $clog2(INPUT_BUF_ENTRIES + 1);

    entry_t           mem [INPUT_BUF_ENTRIES];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             advance_head;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(INPUT_BUF_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid = (count != '0);
    assign data  = mem[head_ptr];
    assign full  = (count == CNT_W'(INPUT_BUF_ENTRIES));

    // head moves on a pop, or when a push overwrites the oldest entry
    assign advance_head = (pop & valid) | (push & full);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (advance_head) begin
                head_ptr <= next_ptr(head_ptr);
            end
            if (push & ~advance_head) begin
                count <= count + 1'b1;
            end else if (~push & advance_head) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[tail_ptr] <= push_data;
        end
    end

endmodule

/* src/ssu_capture.sv */
/*
 * Input stage. Drops updates that cannot change the predictor and buffers
 * each of the four sources in its own overwriting circular buffer.
 */
`timescale 1ns/1ps

module ssu_capture #(
    parameter int INPUT_BUF_ENTRIES = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,

    input  ssu_pkg::cam_update_t ldu_cam,
    input  logic                 ldu_cam_valid,
    input  ssu_pkg::cam_update_t stamofu_cam,
    input  logic                 stamofu_cam_valid,
    input  ssu_pkg::mdp_ref_t    ldu_commit,
    input  logic                 ldu_commit_valid,
    input  ssu_pkg::mdp_ref_t    stamofu_commit,
    input  logic                 stamofu_commit_valid,

    output logic                 ldu_cam_req_valid,
    output ssu_pkg::cam_update_t ldu_cam_req,
    input  logic                 ldu_cam_req_ready,
    output logic                 stamofu_cam_req_valid,
    output ssu_pkg::cam_update_t stamofu_cam_req,
    input  logic                 stamofu_cam_req_ready,
    output logic                 ldu_commit_req_valid,
    output ssu_pkg::mdp_ref_t    ldu_commit_req,
    input  logic                 ldu_commit_req_ready,
    output logic                 stamofu_commit_req_valid,
    output ssu_pkg::mdp_ref_t    stamofu_commit_req,
    input  logic                 stamofu_commit_req_ready
);

    import ssu_pkg::*;

    // ------------------------------------------------------------------------
    // filtering

    // pair already shares one store set at full confidence
    function automatic logic cam_is_useful(input cam_update_t u);
        return !((u.ld.mdp.conf == CONF_FULL) && (u.stamo.mdp.conf == CONF_FULL)
                 && (u.ld.mdp.ssid == u.stamo.mdp.ssid));
    endfunction

    // ------------------------------------------------------------------------
    // input buffers

    ssu_cb #(
        .INPUT_BUF_ENTRIES (INPUT_BUF_ENTRIES),
        .entry_t           (cam_update_t)
    ) u_ldu_cam_cb (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (ldu_cam_valid & cam_is_useful(ldu_cam)),
        .push_data (ldu_cam),
        .valid     (ldu_cam_req_valid),
        .data      (ldu_cam_req),
        .pop       (ldu_cam_req_ready)
    );

    ssu_cb #(
        .INPUT_BUF_ENTRIES (INPUT_BUF_ENTRIES),
        .entry_t           (cam_update_t)
    ) u_stamofu_cam_cb (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (stamofu_cam_valid & cam_is_useful(stamofu_cam)),
        .push_data (stamofu_cam),
        .valid     (stamofu_cam_req_valid),
        .data      (stamofu_cam_req),
        .pop       (stamofu_cam_req_ready)
    );

    // commit with no prediction has nothing to decay
    ssu_cb #(
        .INPUT_BUF_ENTRIES (INPUT_BUF_ENTRIES),
        .entry_t           (mdp_ref_t)
    ) u_ldu_commit_cb (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (ldu_commit_valid & (ldu_commit.mdp.conf != CONF_NONE)),
        .push_data (ldu_commit),
        .valid     (ldu_commit_req_valid),
        .data      (ldu_commit_req),
        .pop       (ldu_commit_req_ready)
    );

    ssu_cb #(
        .INPUT_BUF_ENTRIES (INPUT_BUF_ENTRIES),
        .entry_t           (mdp_ref_t)
    ) u_stamofu_commit_cb (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (stamofu_commit_valid & (stamofu_commit.mdp.conf != CONF_NONE)),
        .push_data (stamofu_commit),
        .valid     (stamofu_commit_req_valid),
        .data      (stamofu_commit_req),
        .pop       (stamofu_commit_req_ready)
    );

endmodule

/* src/ssu_funnel.sv */
/*
 * Fixed-priority funnel from the four buffer heads into a bounded queue.
 * ldu CAM wins over stamofu CAM, and both commits may share one entry.
 */
`timescale 1ns/1ps

module ssu_funnel #(
    parameter int FUNNEL_ENTRIES = 2
) (
    input  logic                   CLK,
    input  logic                   nRST,

    input  logic                   ldu_cam_req_valid,
    input  ssu_pkg::cam_update_t   ldu_cam_req,
    output logic                   ldu_cam_req_ready,
    input  logic                   stamofu_cam_req_valid,
    input  ssu_pkg::cam_update_t   stamofu_cam_req,
    output logic                   stamofu_cam_req_ready,
    input  logic                   ldu_commit_req_valid,
    input  ssu_pkg::mdp_ref_t      ldu_commit_req,
    output logic                   ldu_commit_req_ready,
    input  logic                   stamofu_commit_req_valid,
    input  ssu_pkg::mdp_ref_t      stamofu_commit_req,
    output logic                   stamofu_commit_req_ready,

    output ssu_pkg::funnel_entry_t head,
    output logic                   head_valid,
    input  logic                   head_pop
);

    import ssu_pkg::*;

    localparam int PTR_W = (FUNNEL_ENTRIES > 1) ? $clog2(FUNNEL_ENTRIES) : 1;
    localparam int CNT_W = $clog2(FUNNEL_ENTRIES + 1);

    funnel_entry_t    q_mem [FUNNEL_ENTRIES];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             deq;
    logic             enq_valid;
    funnel_entry_t    enq_entry;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FUNNEL_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // load goes to A, store to B
    function automatic funnel_entry_t cam_entry(input cam_update_t u);
        funnel_entry_t e;
        e.is_cam  = 1'b1;
        e.a_valid = 1'b1;
        e.a       = u.ld;
        e.b_valid = 1'b1;
        e.b       = u.stamo;
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // selection

    always_comb begin
        enq_valid                = 1'b0;
        enq_entry                = '0;
        ldu_cam_req_ready        = 1'b0;
        stamofu_cam_req_ready    = 1'b0;
        ldu_commit_req_ready     = 1'b0;
        stamofu_commit_req_ready = 1'b0;

        if (!full) begin
            if (ldu_cam_req_valid) begin
                ldu_cam_req_ready = 1'b1;
                enq_valid         = 1'b1;
                enq_entry         = cam_entry(ldu_cam_req);
            end else if (stamofu_cam_req_valid) begin
                stamofu_cam_req_ready = 1'b1;
                enq_valid             = 1'b1;
                enq_entry             = cam_entry(stamofu_cam_req);
            end else if (ldu_commit_req_valid | stamofu_commit_req_valid) begin
                // both commits ride together as the A and B halves
                ldu_commit_req_ready     = ldu_commit_req_valid;
                stamofu_commit_req_ready = stamofu_commit_req_valid;
                enq_valid                = 1'b1;
                enq_entry.a_valid        = ldu_commit_req_valid;
                enq_entry.a              = ldu_commit_req;
                enq_entry.b_valid        = stamofu_commit_req_valid;
                enq_entry.b              = stamofu_commit_req;
            end
        end
    end

    // ------------------------------------------------------------------------
    // funnel queue

    assign full       = (count == CNT_W'(FUNNEL_ENTRIES));
    assign head_valid = (count != '0);
    assign head       = q_mem[head_ptr];
    assign deq        = head_pop & head_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (enq_valid) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (deq) begin
                head_ptr <= next_ptr(head_ptr);
            end
            if (enq_valid & ~deq) begin
                count <= count + 1'b1;
            end else if (~enq_valid & deq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_valid) begin
            q_mem[tail_ptr] <= enq_entry;
        end
    end

endmodule

/* src/ssu_resolve.sv */
/*
 * Resolve stage. Turns the funnel head into ROB updates in steps A and B,
 * merging CAM pairs into one store set and decaying committed predictions.
 */
`timescale 1ns/1ps

module ssu_resolve (
    input  logic                   CLK,
    input  logic                   nRST,
    input  ssu_pkg::funnel_entry_t head,
    input  logic                   head_valid,
    output logic                   head_pop,
    output ssu_pkg::rob_update_t   rob_update
);

    import ssu_pkg::*;

    logic              a_done;
    logic              a_done_next;
    logic [SSID_W-1:0] ssid_ctr;
    logic              ssid_alloc;
    logic              a_present;
    logic              b_present;
    logic [SSID_W-1:0] shared_ssid;

    // 3 -> 1, anything else -> 0
    function automatic mdp_info_t decay(input mdp_info_t m);
        mdp_info_t d;
        d.ssid = m.ssid;
        d.conf = (m.conf == CONF_FULL) ? CONF_DECAYED : CONF_NONE;
        return d;
    endfunction

    // ------------------------------------------------------------------------
    // store set choice for a CAM pair

    assign a_present = (head.a.mdp.conf != CONF_NONE);
    assign b_present = (head.b.mdp.conf != CONF_NONE);

    // store side wins when both have a set, fresh set when neither does
    assign shared_ssid = b_present ? head.b.mdp.ssid :
                         a_present ? head.a.mdp.ssid : ssid_ctr;

    // ------------------------------------------------------------------------
    // step control

    always_comb begin
        head_pop    = 1'b0;
        a_done_next = 1'b0;
        ssid_alloc  = 1'b0;
        rob_update  = '0;

        if (head_valid) begin
            rob_update.valid = 1'b1;
            if (head.is_cam) begin
                rob_update.mdp.conf = CONF_FULL;
                rob_update.mdp.ssid = shared_ssid;
                if (!a_done) begin
                    // step A, the load
                    rob_update.rob_idx = head.a.rob_idx;
                    a_done_next        = 1'b1;
                end else begin
                    // step B, the store
                    rob_update.rob_idx = head.b.rob_idx;
                    head_pop           = 1'b1;
                    ssid_alloc         = !a_present && !b_present;
                end
            end else if (head.a_valid && !a_done) begin
                rob_update.mdp     = decay(head.a.mdp);
                rob_update.rob_idx = head.a.rob_idx;
                if (head.b_valid) begin
                    a_done_next = 1'b1;
                end else begin
                    head_pop = 1'b1;
                end
            end else begin
                rob_update.valid   = head.b_valid;
                rob_update.mdp     = decay(head.b.mdp);
                rob_update.rob_idx = head.b.rob_idx;
                head_pop           = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            a_done   <= 1'b0;
            ssid_ctr <= '0;
        end else begin
            a_done <= a_done_next;
            // round-robin allocation, wraps over all store sets
            if (ssid_alloc) begin
                ssid_ctr <= ssid_ctr + 1'b1;
            end
        end
    end

endmodule

/* src/ssu_top.sv */
/*
 * Store set updater top level. Chains capture, funnel and resolve stages and
 * drives one ROB mdp update per cycle at most.
 */
`timescale 1ns/1ps

module ssu_top #(
    parameter int INPUT_BUF_ENTRIES = 2,
    parameter int FUNNEL_ENTRIES    = 2
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  ssu_pkg::cam_update_t ldu_cam,
    input  logic                 ldu_cam_valid,
    input  ssu_pkg::cam_update_t stamofu_cam,
    input  logic                 stamofu_cam_valid,
    input  ssu_pkg::mdp_ref_t    ldu_commit,
    input  logic                 ldu_commit_valid,
    input  ssu_pkg::mdp_ref_t    stamofu_commit,
    input  logic                 stamofu_commit_valid,
    output ssu_pkg::rob_update_t rob_update
);

    import ssu_pkg::*;

    // ------------------------------------------------------------------------
    // buffer heads
    logic          ldu_cam_req_valid;
    cam_update_t   ldu_cam_req;
    logic          ldu_cam_req_ready;
    logic          stamofu_cam_req_valid;
    cam_update_t   stamofu_cam_req;
    logic          stamofu_cam_req_ready;
    logic          ldu_commit_req_valid;
    mdp_ref_t      ldu_commit_req;
    logic          ldu_commit_req_ready;
    logic          stamofu_commit_req_valid;
    mdp_ref_t      stamofu_commit_req;
    logic          stamofu_commit_req_ready;

    // funnel head
    funnel_entry_t head;
    logic          head_valid;
    logic          head_pop;

    ssu_capture #(
        .INPUT_BUF_ENTRIES (INPUT_BUF_ENTRIES)
    ) u_capture (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .ldu_cam                  (ldu_cam),
        .ldu_cam_valid            (ldu_cam_valid),
        .stamofu_cam              (stamofu_cam),
        .stamofu_cam_valid        (stamofu_cam_valid),
        .ldu_commit               (ldu_commit),
        .ldu_commit_valid         (ldu_commit_valid),
        .stamofu_commit           (stamofu_commit),
        .stamofu_commit_valid     (stamofu_commit_valid),
        .ldu_cam_req_valid        (ldu_cam_req_valid),
        .ldu_cam_req              (ldu_cam_req),
        .ldu_cam_req_ready        (ldu_cam_req_ready),
        .stamofu_cam_req_valid    (stamofu_cam_req_valid),
        .stamofu_cam_req          (stamofu_cam_req),
        .stamofu_cam_req_ready    (stamofu_cam_req_ready),
        .ldu_commit_req_valid     (ldu_commit_req_valid),
        .ldu_commit_req           (ldu_commit_req),
        .ldu_commit_req_ready     (ldu_commit_req_ready),
        .stamofu_commit_req_valid (stamofu_commit_req_valid),
        .stamofu_commit_req       (stamofu_commit_req),
        .stamofu_commit_req_ready (stamofu_commit_req_ready)
    );

    ssu_funnel #(
        .FUNNEL_ENTRIES (FUNNEL_ENTRIES)
    ) u_funnel (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .ldu_cam_req_valid        (ldu_cam_req_valid),
        .ldu_cam_req              (ldu_cam_req),
        .ldu_cam_req_ready        (ldu_cam_req_ready),
        .stamofu_cam_req_valid    (stamofu_cam_req_valid),
        .stamofu_cam_req          (stamofu_cam_req),
        .stamofu_cam_req_ready    (stamofu_cam_req_ready),
        .ldu_commit_req_valid     (ldu_commit_req_valid),
        .ldu_commit_req           (ldu_commit_req),
        .ldu_commit_req_ready     (ldu_commit_req_ready),
        .stamofu_commit_req_valid (stamofu_commit_req_valid),
        .stamofu_commit_req       (stamofu_commit_req),
        .stamofu_commit_req_ready (stamofu_commit_req_ready),
        .head                     (head),
        .head_valid               (head_valid),
        .head_pop                 (head_pop)
    );

    ssu_resolve u_resolve (
        .CLK        (CLK),
        .nRST       (nRST),
        .head       (head),
        .head_valid (head_valid),
        .head_pop   (head_pop),
        .rob_update (rob_update)
    );

endmodule

/* tests/ssu_props.sv */
/*
 * Concurrent checks on the resolve stage outputs, bound into every ssu_resolve.
 */
`timescale 1ns/1ps

module ssu_props (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 head_valid,
    input logic                 head_pop,
    input ssu_pkg::rob_update_t rob_update
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // confidence 2 is never produced by merge or decay
    conf_legal: assert property (@(posedge CLK) disable iff (!nRST)
        rob_update.valid |-> (rob_update.mdp.conf != 2'd2))
        else begin
            $error("ROB update carries confidence 2");
            fail_count++;
        end

    valid_needs_head: assert property (@(posedge CLK) disable iff (!nRST)
        rob_update.valid |-> head_valid)
        else begin
            $error("ROB update valid with no funnel head");
            fail_count++;
        end

    pop_needs_head: assert property (@(posedge CLK) disable iff (!nRST)
        head_pop |-> head_valid)
        else begin
            $error("head_pop raised with no funnel head");
            fail_count++;
        end

    // funnel is empty right out of reset, so nothing may be sent
    quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> (!head_valid && !rob_update.valid))
        else begin
            $error("ROB update valid before any head was present");
            fail_count++;
        end

endmodule

bind ssu_resolve ssu_props u_props (
    .CLK        (CLK),
    .nRST       (nRST),
    .head_valid (head_valid),
    .head_pop   (head_pop),
    .rob_update (rob_update)
);

/* tests/ssu_tb.sv */
/*
 * Testbench for the store set updater. Sends CAM and commit updates, predicts
 * the ROB updates with a reference model and checks each one as it appears.
 */
`timescale 1ns/1ps

module ssu_tb;

    import ssu_pkg::*;

    logic                 CLK;
    logic                 nRST;
    cam_update_t          ldu_cam;
    logic                 ldu_cam_valid;
    cam_update_t          stamofu_cam;
    logic                 stamofu_cam_valid;
    mdp_ref_t             ldu_commit;
    logic                 ldu_commit_valid;
    mdp_ref_t             stamofu_commit;
    logic                 stamofu_commit_valid;
    rob_update_t          rob_update;

    rob_update_t          exp_q [$];
    rob_update_t          obs_q [$];
    logic                 collect_only;
    int                   errors;
    int                   tests_run;
    int                   tests_bad;
    integer               seed;
    logic [SSID_W-1:0]    ssid_model;
    logic [ROB_IDX_W-1:0] next_idx;

    ssu_top #(
        .INPUT_BUF_ENTRIES (2),
        .FUNNEL_ENTRIES    (2)
    ) u_ssu_top (
        .CLK                  (CLK),
        .nRST                 (nRST),
        .ldu_cam              (ldu_cam),
        .ldu_cam_valid        (ldu_cam_valid),
        .stamofu_cam          (stamofu_cam),
        .stamofu_cam_valid    (stamofu_cam_valid),
        .ldu_commit           (ldu_commit),
        .ldu_commit_valid     (ldu_commit_valid),
        .stamofu_commit       (stamofu_commit),
        .stamofu_commit_valid (stamofu_commit_valid),
        .rob_update           (rob_update)
    );

    always #2 CLK = ~CLK;

    // ------------------------------------------------------------------------
    // reference model

    function automatic void ref_update(input logic is_cam, input cam_update_t cu,
                                       input logic ld_v, input mdp_ref_t ldc,
                                       input logic st_v, input mdp_ref_t stc);
        rob_update_t u;
        u       = '0;
        u.valid = 1'b1;
        if (is_cam) begin
            // already in one set at full confidence
            if (cu.ld.mdp.conf == 2'd3 && cu.stamo.mdp.conf == 2'd3
                && cu.ld.mdp.ssid == cu.stamo.mdp.ssid) begin
                return;
            end
            u.mdp.conf = 2'd3;
            if (cu.stamo.mdp.conf != 2'd0) begin
                u.mdp.ssid = cu.stamo.mdp.ssid;
            end else if (cu.ld.mdp.conf != 2'd0) begin
                u.mdp.ssid = cu.ld.mdp.ssid;
            end else begin
                u.mdp.ssid = ssid_model;
                ssid_model = ssid_model + 1'b1;
            end
            u.rob_idx = cu.ld.rob_idx;
            exp_q.push_back(u);
            u.rob_idx = cu.stamo.rob_idx;
            exp_q.push_back(u);
        end else begin
            if (ld_v && ldc.mdp.conf != 2'd0) begin
                u.mdp.ssid = ldc.mdp.ssid;
                u.mdp.conf = (ldc.mdp.conf == 2'd3) ? 2'd1 : 2'd0;
                u.rob_idx  = ldc.rob_idx;
                exp_q.push_back(u);
            end
            if (st_v && stc.mdp.conf != 2'd0) begin
                u.mdp.ssid = stc.mdp.ssid;
                u.mdp.conf = (stc.mdp.conf == 2'd3) ? 2'd1 : 2'd0;
                u.rob_idx  = stc.rob_idx;
                exp_q.push_back(u);
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // comparison at mid-cycle where outputs have settled

    always @(negedge CLK) begin
        rob_update_t want;
        if (nRST && rob_update.valid) begin
            if (collect_only) begin
                obs_q.push_back(rob_update);
            end else if (exp_q.size() == 0) begin
                $display("unexpected ROB update for rob_idx %0d at %0t",
                         rob_update.rob_idx, $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                if (rob_update.rob_idx != want.rob_idx) begin
                    $display("Fail at %0t: rob_update.rob_idx expected %0d got %0d",
                             $time, want.rob_idx, rob_update.rob_idx);
                    errors++;
                end
                if (rob_update.mdp.conf != want.mdp.conf) begin
                    $display("Fail at %0t: rob_update.mdp.conf expected %0d got %0d",
                             $time, want.mdp.conf, rob_update.mdp.conf);
                    errors++;
                end
                if (rob_update.mdp.ssid != want.mdp.ssid) begin
                    $display("Fail at %0t: rob_update.mdp.ssid expected %0d got %0d",
                             $time, want.mdp.ssid, rob_update.mdp.ssid);
                    errors++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus helpers

    function automatic int rand_below(input int n);
        logic [31:0] rnd;
        rnd = $random(seed);
        return int'(rnd[15:0]) % n;
    endfunction

    function automatic logic [CONF_W-1:0] rand_conf();
        return CONF_W'(1 + rand_below(3));
    endfunction

    // fresh ROB index per reference so every update is distinguishable
    function automatic mdp_ref_t make_ref(input logic [CONF_W-1:0] conf);
        mdp_ref_t    r;
        logic [31:0] rnd;
        rnd        = $random(seed);
        r.mdp.conf = conf;
        r.mdp.ssid = rnd[SSID_W-1:0];
        r.rob_idx  = next_idx;
        next_idx   = next_idx + 1'b1;
        return r;
    endfunction

    task automatic drive_cycle(input logic lc_v, input cam_update_t lc,
                               input logic sc_v, input cam_update_t sc,
                               input logic lm_v, input mdp_ref_t lm,
                               input logic sm_v, input mdp_ref_t sm);
        @(posedge CLK);
        #0.5;
        ldu_cam              = lc;
        ldu_cam_valid        = lc_v;
        stamofu_cam          = sc;
        stamofu_cam_valid    = sc_v;
        ldu_commit           = lm;
        ldu_commit_valid     = lm_v;
        stamofu_commit       = sm;
        stamofu_commit_valid = sm_v;
    endtask

    task automatic clear_inputs();
        @(posedge CLK);
        #0.5;
        ldu_cam_valid        = 1'b0;
        stamofu_cam_valid    = 1'b0;
        ldu_commit_valid     = 1'b0;
        stamofu_commit_valid = 1'b0;
    endtask

    task automatic send_cam(input logic from_stamofu, input cam_update_t cu);
        drive_cycle(!from_stamofu, cu, from_stamofu, cu, 1'b0, '0, 1'b0, '0);
        ref_update(1'b1, cu, 1'b0, '0, 1'b0, '0);
        clear_inputs();
    endtask

    task automatic send_commits(input logic ld_v, input mdp_ref_t ldc,
                                input logic st_v, input mdp_ref_t stc);
        drive_cycle(1'b0, '0, 1'b0, '0, ld_v, ldc, st_v, stc);
        ref_update(1'b0, '0, ld_v, ldc, st_v, stc);
        clear_inputs();
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge CLK);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected ROB updates never appeared", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // waits until the last update of the burst shows up
    task automatic wait_last_seen(input int max_cycles);
        int n;
        n = 0;
        while (!(obs_q.size() != 0 && obs_q[$] == exp_q[$]) && n < max_cycles) begin
            @(posedge CLK);
            n++;
        end
        if (!(obs_q.size() != 0 && obs_q[$] == exp_q[$])) begin
            $display("timeout: last update of the burst never appeared");
            errors++;
        end
    endtask

    task automatic check_subsequence();
        int k;
        k = 0;
        for (int i = 0; i < obs_q.size(); i++) begin
            while (k < exp_q.size() && exp_q[k] != obs_q[i]) begin
                k++;
            end
            if (k == exp_q.size()) begin
                $display("ROB update for rob_idx %0d is out of order or was never sent",
                         obs_q[i].rob_idx);
                errors++;
                break;
            end
            k++;
        end
        if (obs_q.size() < 2 || obs_q[$] != exp_q[$]) begin
            $display("Fail at %0t: rob_update.rob_idx expected %0d got %0d", $time,
                     exp_q[$].rob_idx, (obs_q.size() != 0) ? obs_q[$].rob_idx : 7'd0);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-24s ok", name);
        end else begin
            tests_bad++;
            $display("test %-24s %0d errors", name, errors - errs_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence

    initial begin
        int          errs_before;
        int          kind;
        cam_update_t cu;
        cam_update_t cu2;
        mdp_ref_t    lc_ref;
        mdp_ref_t    sc_ref;
        CLK = 1'b0;
        nRST = 1'b0;
        ldu_cam = '0;
        ldu_cam_valid = 1'b0;
        stamofu_cam = '0;
        stamofu_cam_valid = 1'b0;
        ldu_commit = '0;
        ldu_commit_valid = 1'b0;
        stamofu_commit = '0;
        stamofu_commit_valid = 1'b0;
        collect_only = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        seed = 32'h5eb9;
        ssid_model = '0;
        next_idx = '0;
        repeat (5) @(posedge CLK);
        #0.5;
        nRST = 1'b1;

        errs_before = errors;
        for (int i = 0; i < 3; i++) begin
            cu.ld    = make_ref(CONF_NONE);
            cu.stamo = make_ref(CONF_NONE);
            send_cam(1'b0, cu);
            wait_drained(40);
        end
        end_test("new ssid allocation", errs_before);

        errs_before = errors;
        for (int i = 0; i < 8; i++) begin
            kind     = rand_below(3);
            cu.ld    = make_ref((kind == 1) ? CONF_NONE : rand_conf());
            cu.stamo = make_ref((kind == 0) ? CONF_NONE : rand_conf());
            if (kind == 2 && cu.ld.mdp.ssid == cu.stamo.mdp.ssid) begin
                cu.stamo.mdp.ssid[0] = ~cu.stamo.mdp.ssid[0];
            end
            send_cam(i[0], cu);
            wait_drained(40);
        end
        // next fresh set shows whether the counter moved
        cu.ld    = make_ref(CONF_NONE);
        cu.stamo = make_ref(CONF_NONE);
        send_cam(1'b1, cu);
        wait_drained(40);
        end_test("ssid selection", errs_before);

        errs_before = errors;
        cu.ld    = make_ref(CONF_FULL);
        cu.stamo = make_ref(CONF_FULL);
        cu.stamo.mdp.ssid = cu.ld.mdp.ssid;
        send_cam(1'b0, cu);
        send_commits(1'b1, make_ref(CONF_NONE), 1'b1, make_ref(CONF_NONE));
        repeat (20) @(posedge CLK);
        end_test("filtering", errs_before);

        errs_before = errors;
        for (int i = 0; i < 4; i++) begin
            send_commits(1'b1, make_ref(rand_conf()), 1'b1, make_ref(rand_conf()));
            wait_drained(40);
            send_commits(1'b1, make_ref(rand_conf()), 1'b0, '0);
            wait_drained(40);
            send_commits(1'b0, '0, 1'b1, make_ref(rand_conf()));
            wait_drained(40);
        end
        end_test("commit decay", errs_before);

        errs_before = errors;
        cu.ld     = make_ref(CONF_NONE);
        cu.stamo  = make_ref(CONF_NONE);
        cu2.ld    = make_ref(rand_conf());
        cu2.stamo = make_ref(CONF_NONE);
        lc_ref    = make_ref(rand_conf());
        sc_ref    = make_ref(rand_conf());
        drive_cycle(1'b1, cu, 1'b1, cu2, 1'b1, lc_ref, 1'b1, sc_ref);
        ref_update(1'b1, cu, 1'b0, '0, 1'b0, '0);
        ref_update(1'b1, cu2, 1'b0, '0, 1'b0, '0);
        ref_update(1'b0, '0, 1'b1, lc_ref, 1'b1, sc_ref);
        clear_inputs();
        wait_drained(80);
        collect_only = 1'b1;
        for (int i = 0; i < 6; i++) begin
            cu.ld    = make_ref(CONF_NONE);
            cu.stamo = make_ref(rand_conf());
            drive_cycle(1'b1, cu, 1'b0, '0, 1'b0, '0, 1'b0, '0);
            ref_update(1'b1, cu, 1'b0, '0, 1'b0, '0);
        end
        clear_inputs();
        wait_last_seen(100);
        check_subsequence();
        collect_only = 1'b0;
        exp_q.delete();
        obs_q.delete();
        end_test("priority and overflow", errs_before);

        errors = errors + u_ssu_top.u_resolve.u_props.fail_count;
        $display("%0d tests, %0d with errors, %0d errors, %0d assertion failures",
                 tests_run, tests_bad, errors, u_ssu_top.u_resolve.u_props.fail_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* ssu_top.f */
src/ssu_pkg.sv
src/ssu_cb.sv
src/ssu_capture.sv
src/ssu_funnel.sv
src/ssu_resolve.sv
src/ssu_top.sv
tests/ssu_props.sv
tests/ssu_tb.sv
